//--- Bender.yml
package:
  name: nx_node

sources:
  # Design sources in compile order
  - files:
      - logic/nx_pkg.sv
      - logic/nx_ram.sv
      - logic/nx_node_store.sv
      - logic/nx_msg_decoder.sv
      - logic/nx_node_core.sv
      - logic/nx_node.sv

  # Testbench and its reference model header
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/nx_node_tb.sv

//--- all.f
+incdir+include
logic/nx_pkg.sv
logic/nx_ram.sv
logic/nx_node_store.sv
logic/nx_msg_decoder.sv
logic/nx_node_core.sv
logic/nx_node.sv
dv/nx_node_tb.sv

//--- include/nx_node_model.svh
`ifndef NX_NODE_MODEL_SVH
`define NX_NODE_MODEL_SVH

// Reference model of one logic node
// Included inside the testbench module

// Appended instructions in load order
nx_pkg::nx_instr_t model_instrs [$];
// Control block contents
logic [nx_pkg::NX_CTRL_W-1:0] model_ctrl [2 ** nx_pkg::NX_ADDR_W];
// Working registers, kept between runs
logic [nx_pkg::NX_REGS-1:0] model_regs;

// Post-reset state
function automatic void model_reset();
    model_instrs.delete();
    foreach (model_ctrl[i]) begin
        model_ctrl[i] = '0;
    end
    model_regs = '0;
endfunction

// Append one instruction
function automatic void model_load(input nx_pkg::nx_instr_t instr);
    model_instrs.push_back(instr);
endfunction

// Count seen by a trigger issued now
function automatic int model_count();
    return model_instrs.size();
endfunction

function automatic void model_ctrl_write(
    input int                           addr,
    input logic [nx_pkg::NX_CTRL_W-1:0] data
);
    model_ctrl[addr] = data;
endfunction

// Expected read data
function automatic logic [nx_pkg::NX_CTRL_W-1:0] model_ctrl_read(input int addr);
    return model_ctrl[addr];
endfunction

// Single two-input operation
function automatic logic model_op(input nx_pkg::nx_op_e op, input logic a, input logic b);
    case (op)
        nx_pkg::OP_INVERT: return ~a;
        nx_pkg::OP_AND:    return a & b;
        nx_pkg::OP_NAND:   return ~(a & b);
        nx_pkg::OP_OR:     return a | b;
        nx_pkg::OP_NOR:    return ~(a | b);
        nx_pkg::OP_XOR:    return a ^ b;
        nx_pkg::OP_XNOR:   return ~(a ^ b);
        default:           return a;
    endcase
endfunction

// One run over the first count instructions
function automatic logic [nx_pkg::NX_REGS-1:0] model_run(
    input logic [7:0] trig,
    input int         count
);
    nx_pkg::nx_instr_t ins;
    model_regs[7:0] = trig;
    for (int i = 0; i < count; i++) begin
        ins = model_instrs[i];
        model_regs[ins.tgt] = model_op(ins.op, model_regs[ins.src_a], model_regs[ins.src_b]);
    end
    return model_regs;
endfunction

`endif

//--- dv/nx_node_tb.sv
module nx_node_tb;

timeunit 1ns;
timeprecision 100ps;

localparam int MAX_INSTRS     = 512;
localparam int MAX_CTRL       = 512;
// Upper bound for any wait, in clock cycles
localparam int TIMEOUT_CYCLES = 4000;

logic                         clk_i;
logic                         rst_i;
logic                         msg_valid_i;
nx_pkg::nx_msg_t              msg_i;
logic                         resp_valid_o;
logic [nx_pkg::NX_CTRL_W-1:0] resp_data_o;
logic                         busy_o;
logic                         done_o;
logic [nx_pkg::NX_REGS-1:0]   regs_o;

// Error bookkeeping
int    errors;
int    tests_run;
int    tests_failed;
int    test_err_base;
string test_name;

`include "nx_node_model.svh"

nx_node #(
      .MAX_INSTRS(MAX_INSTRS)
    , .MAX_CTRL  (MAX_CTRL  )
) u_nx_node (
      .clk_i       (clk_i       )
    , .rst_i       (rst_i       )
    , .msg_valid_i (msg_valid_i )
    , .msg_i       (msg_i       )
    , .resp_valid_o(resp_valid_o)
    , .resp_data_o (resp_data_o )
    , .busy_o      (busy_o      )
    , .done_o      (done_o      )
    , .regs_o      (regs_o      )
);

// 100 ns clock
initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
end

task automatic start_test(input string name);
    test_name     = name;
    test_err_base = errors;
endtask

// One line per finished test
task automatic finish_test();
    tests_run++;
    if (errors > test_err_base) begin
        tests_failed++;
        $display("test %s: %0d errors", test_name, errors - test_err_base);
    end else begin
        $display("test %s: ok", test_name);
    end
endtask

task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
        $display("mismatch %s expected 0x%0h actual 0x%0h", sig, exp, act);
        errors++;
    end
endtask

task automatic idle(input int n);
    repeat (n) @(negedge clk_i);
endtask

// Single-cycle command strobe, returns at the next falling edge
task automatic send_msg(
    input nx_pkg::nx_cmd_e              cmd,
    input logic [nx_pkg::NX_ADDR_W-1:0] addr,
    input logic [nx_pkg::NX_INSTR_W-1:0] data
);
    msg_i.cmd   = cmd;
    msg_i.addr  = addr;
    msg_i.data  = data;
    msg_valid_i = 1'b1;
    @(negedge clk_i);
    msg_valid_i = 1'b0;
endtask

// Cycles counted from the strobe that started the wait
task automatic wait_done(output int cycles);
    cycles = 1;
    while (!done_o && cycles < TIMEOUT_CYCLES) begin
        @(negedge clk_i);
        cycles++;
    end
    assert (done_o) else begin
        $display("timeout waiting for done_o after %0d cycles", cycles);
        errors++;
    end
endtask

task automatic wait_resp(output int cycles);
    cycles = 1;
    while (!resp_valid_o && cycles < TIMEOUT_CYCLES) begin
        @(negedge clk_i);
        cycles++;
    end
    assert (resp_valid_o) else begin
        $display("timeout waiting for resp_valid_o after %0d cycles", cycles);
        errors++;
    end
endtask

// Append one random instruction to DUT and model
task automatic load_random();
    logic [nx_pkg::NX_INSTR_W-1:0] bits;
    nx_pkg::nx_instr_t             ins;
    bits = nx_pkg::NX_INSTR_W'($urandom);
    ins  = nx_pkg::nx_instr_t'(bits);
    send_msg(nx_pkg::CMD_LOAD_INSTR, '0, bits);
    model_load(ins);
endtask

// Read must answer exactly one cycle later
task automatic read_ctrl(input logic [nx_pkg::NX_ADDR_W-1:0] addr);
    int cycles;
    send_msg(nx_pkg::CMD_CTRL_READ, addr, '0);
    wait_resp(cycles);
    assert (cycles == 1) else begin
        $display("read response at address %0h came after %0d cycles, not one", addr, cycles);
        errors++;
    end
    check_value("resp_data_o", model_ctrl_read(addr), resp_data_o);
endtask

task automatic write_ctrl(
    input logic [nx_pkg::NX_ADDR_W-1:0] addr,
    input logic [nx_pkg::NX_CTRL_W-1:0] data
);
    send_msg(nx_pkg::CMD_CTRL_WRITE, addr, nx_pkg::NX_INSTR_W'(data));
    model_ctrl_write(addr, data);
endtask

task automatic trigger_run(input logic [7:0] trig);
    send_msg(nx_pkg::CMD_TRIGGER, '0, nx_pkg::NX_INSTR_W'(trig));
endtask

initial begin
    int                           seed_dummy;
    int                           cycles;
    int                           snap;
    int                           n;
    int                           pulses;
    logic [7:0]                   trig;
    logic [nx_pkg::NX_ADDR_W-1:0] addr;
    logic [nx_pkg::NX_CTRL_W-1:0] data;
    logic [nx_pkg::NX_REGS-1:0]   exp_regs;
    int                           written [$];

    rst_i        = 1'b1;
    msg_valid_i  = 1'b0;
    msg_i        = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    seed_dummy   = $urandom(5);
    model_reset();

    // Five cycles of reset, released on a falling edge
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;

    start_test("reset state");
    check_value("busy_o", 0, busy_o);
    check_value("done_o", 0, done_o);
    check_value("resp_valid_o", 0, resp_valid_o);
    check_value("regs_o", 0, regs_o);
    finish_test();

    start_test("control block");
    for (int i = 0; i < 16; i++) begin
        addr = nx_pkg::NX_ADDR_W'($urandom_range(0, MAX_CTRL - 1));
        data = nx_pkg::NX_CTRL_W'($urandom);
        write_ctrl(addr, data);
        written.push_back(addr);
    end
    // Only entries that hold data are read back
    for (int i = 0; i < 16; i++) begin
        read_ctrl(written[$urandom_range(0, written.size() - 1)]);
    end
    // Read on the cycle right after the write
    for (int i = 0; i < 8; i++) begin
        addr = nx_pkg::NX_ADDR_W'($urandom_range(0, MAX_CTRL - 1));
        data = nx_pkg::NX_CTRL_W'($urandom);
        write_ctrl(addr, data);
        read_ctrl(addr);
    end
    finish_test();

    start_test("empty run");
    trig = 8'($urandom);
    trigger_run(trig);
    wait_done(cycles);
    assert (cycles == 1) else begin
        $display("empty run took %0d cycles to done_o instead of one", cycles);
        errors++;
    end
    exp_regs = model_run(trig, 0);
    check_value("regs_o", {8'h00, trig}, regs_o);
    check_value("regs_o", exp_regs, regs_o);
    idle(1);
    finish_test();

    start_test("random program");
    // Upper registers carry over from run to run
    for (int r = 0; r < 3; r++) begin
        n = $urandom_range(20, 40);
        for (int k = 0; k < n; k++) begin
            load_random();
        end
        trig = 8'($urandom);
        snap = model_count();
        trigger_run(trig);
        wait_done(cycles);
        check_value("regs_o", model_run(trig, snap), regs_o);
        idle(1);
    end
    finish_test();

    start_test("loads during run");
    trig = 8'($urandom);
    snap = model_count();
    trigger_run(trig);
    n = $urandom_range(8, 16);
    for (int k = 0; k < n; k++) begin
        assert (busy_o) else begin
            $display("busy_o low while appending instruction %0d of the mid-run loads", k);
            errors++;
        end
        load_random();
        if ($urandom_range(0, 1) == 1) begin
            idle(1);
        end
    end
    wait_done(cycles);
    // Only the snapshotted count runs
    check_value("regs_o", model_run(trig, snap), regs_o);
    idle(1);
    trig = 8'($urandom);
    snap = model_count();
    trigger_run(trig);
    wait_done(cycles);
    check_value("regs_o", model_run(trig, snap), regs_o);
    idle(1);
    finish_test();

    start_test("trigger while busy");
    trig = 8'($urandom);
    snap = model_count();
    exp_regs = model_run(trig, snap);
    trigger_run(trig);
    idle($urandom_range(2, 10));
    assert (busy_o) else begin
        $display("core not busy when the second trigger was sent");
        errors++;
    end
    // Different inputs so an accepted second trigger shows in the result
    trigger_run(~trig);
    wait_done(cycles);
    pulses = done_o ? 1 : 0;
    check_value("regs_o", exp_regs, regs_o);
    // A restarted run would pulse done again
    for (int k = 0; k < 2 * snap + 20; k++) begin
        @(negedge clk_i);
        if (done_o) begin
            pulses++;
        end
    end
    assert (pulses == 1) else begin
        $display("saw %0d done_o pulses where exactly one was expected", pulses);
        errors++;
    end
    check_value("busy_o", 0, busy_o);
    check_value("regs_o", exp_regs, regs_o);
    finish_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
        $display("TEST RESULT: PASS");
    end else begin
        $display("TEST RESULT: FAIL");
    end
    $finish;
end

endmodule : nx_node_tb

//--- logic/nx_msg_decoder.sv
// Command message decode
// Turns each strobed message into store, control or trigger strobes
module nx_msg_decoder (
      input  logic                           clk_i
    , input  logic                           rst_i
    // Inbound message
    , input  logic                           msg_valid_i
    , input  nx_pkg::nx_msg_t                msg_i
    // Instruction append
    , output logic                           store_valid_o
    , output nx_pkg::nx_instr_t              store_data_o
    // Control block access
    , output logic [nx_pkg::NX_ADDR_W-1:0]   ctrl_addr_o
    , output logic [nx_pkg::NX_CTRL_W-1:0]   ctrl_wr_data_o
    , output logic                           ctrl_wr_en_o
    , output logic                           ctrl_rd_en_o
    , input  logic [nx_pkg::NX_CTRL_W-1:0]   ctrl_rd_data_i
    // Run trigger
    , output logic                           trigger_o
    , output logic [7:0]                     trig_inputs_o
    // Read response
    , output logic                           resp_valid_o
    , output logic [nx_pkg::NX_CTRL_W-1:0]   resp_data_o
);

// Read issued last cycle
logic rd_pend_q;

// Payload fields pass straight through
assign store_data_o   = nx_pkg::nx_instr_t'(msg_i.data);
assign ctrl_addr_o    = msg_i.addr;
assign ctrl_wr_data_o = msg_i.data[nx_pkg::NX_CTRL_W-1:0];
assign trig_inputs_o  = msg_i.data[7:0];

// One strobe per command
always_comb begin : p_decode
    store_valid_o = 1'b0;
    ctrl_wr_en_o  = 1'b0;
    ctrl_rd_en_o  = 1'b0;
    trigger_o     = 1'b0;
    if (msg_valid_i) begin
        case (msg_i.cmd)
            nx_pkg::CMD_LOAD_INSTR: store_valid_o = 1'b1;
            nx_pkg::CMD_CTRL_WRITE: ctrl_wr_en_o  = 1'b1;
            nx_pkg::CMD_CTRL_READ:  ctrl_rd_en_o  = 1'b1;
            nx_pkg::CMD_TRIGGER:    trigger_o     = 1'b1;
        endcase
    end
end

// Store read data lands one cycle after the request
always_ff @(posedge clk_i, posedge rst_i) begin : p_resp
    if (rst_i) begin
        rd_pend_q <= 1'b0;
    end else begin
        rd_pend_q <= ctrl_rd_en_o;
    end
end

assign resp_valid_o = rd_pend_q;
// Meaningful only alongside resp_valid_o
assign resp_data_o  = ctrl_rd_data_i;

endmodule : nx_msg_decoder

//--- logic/nx_node.sv
// Logic node top
// Decoder, storage and core wired together
module nx_node #(
      parameter int MAX_INSTRS = 512
    , parameter int MAX_CTRL   = 512
) (
      input  logic                           clk_i
    , input  logic                           rst_i
    // Inbound commands
    , input  logic                           msg_valid_i
    , input  nx_pkg::nx_msg_t                msg_i
    // Control read responses
    , output logic                           resp_valid_o
    , output logic [nx_pkg::NX_CTRL_W-1:0]   resp_data_o
    // Run status and result
    , output logic                           busy_o
    , output logic                           done_o
    , output logic [nx_pkg::NX_REGS-1:0]     regs_o
);

localparam int INSTR_ADDR_W = $clog2(MAX_INSTRS);
localparam int CTRL_ADDR_W  = $clog2(MAX_CTRL);
localparam int MSG_ADDR_W   = nx_pkg::NX_ADDR_W;

// Decoder to store
logic                          store_valid;
nx_pkg::nx_instr_t             store_data;
logic [MSG_ADDR_W-1:0]         ctrl_addr;
logic [nx_pkg::NX_CTRL_W-1:0]  ctrl_wr_data;
logic                          ctrl_wr_en;
logic                          ctrl_rd_en;
logic [nx_pkg::NX_CTRL_W-1:0]  ctrl_rd_data;
// Decoder to core
logic                          trigger;
logic [7:0]                    trig_inputs;
// Core to store
logic [MSG_ADDR_W-1:0]         fetch_addr;
logic                          fetch_rd;
nx_pkg::nx_instr_t             fetch_data;
logic                          fetch_stall;
logic [INSTR_ADDR_W-1:0]       instr_count;

nx_msg_decoder u_decoder (
      .clk_i         (clk_i       )
    , .rst_i         (rst_i       )
    , .msg_valid_i   (msg_valid_i )
    , .msg_i         (msg_i       )
    , .store_valid_o (store_valid )
    , .store_data_o  (store_data  )
    , .ctrl_addr_o   (ctrl_addr   )
    , .ctrl_wr_data_o(ctrl_wr_data)
    , .ctrl_wr_en_o  (ctrl_wr_en  )
    , .ctrl_rd_en_o  (ctrl_rd_en  )
    , .ctrl_rd_data_i(ctrl_rd_data)
    , .trigger_o     (trigger     )
    , .trig_inputs_o (trig_inputs )
    , .resp_valid_o  (resp_valid_o)
    , .resp_data_o   (resp_data_o )
);

nx_node_store #(
      .MAX_INSTRS(MAX_INSTRS)
    , .MAX_CTRL  (MAX_CTRL  )
) u_store (
      .clk_i         (clk_i                             )
    , .rst_i         (rst_i                             )
    , .instr_count_o (instr_count                       )
    , .store_data_i  (store_data                        )
    , .store_valid_i (store_valid                       )
    , .fetch_addr_i  (fetch_addr[INSTR_ADDR_W-1:0]      )
    , .fetch_rd_i    (fetch_rd                          )
    , .fetch_data_o  (fetch_data                        )
    , .fetch_stall_o (fetch_stall                       )
    , .ctrl_addr_i   (ctrl_addr[CTRL_ADDR_W-1:0]        )
    , .ctrl_wr_data_i(ctrl_wr_data                      )
    , .ctrl_wr_en_i  (ctrl_wr_en                        )
    , .ctrl_rd_en_i  (ctrl_rd_en                        )
    , .ctrl_rd_data_o(ctrl_rd_data                      )
);

nx_node_core u_core (
      .clk_i        (clk_i                   )
    , .rst_i        (rst_i                   )
    , .trigger_i    (trigger                 )
    , .trig_inputs_i(trig_inputs             )
    , .instr_count_i(MSG_ADDR_W'(instr_count))
    , .fetch_addr_o (fetch_addr              )
    , .fetch_rd_o   (fetch_rd                )
    , .fetch_data_i (fetch_data              )
    , .fetch_stall_i(fetch_stall             )
    , .busy_o       (busy_o                  )
    , .done_o       (done_o                  )
    , .regs_o       (regs_o                  )
);

endmodule : nx_node

//--- logic/nx_node_core.sv
// Instruction sequencer and logic evaluator
// Walks the instruction list once per trigger over 16 one-bit registers
module nx_node_core (
      input  logic                           clk_i
    , input  logic                           rst_i
    // Run trigger
    , input  logic                           trigger_i
    , input  logic [7:0]                     trig_inputs_i
    , input  logic [nx_pkg::NX_ADDR_W-1:0]   instr_count_i
    // Instruction fetch
    , output logic [nx_pkg::NX_ADDR_W-1:0]   fetch_addr_o
    , output logic                           fetch_rd_o
    , input  nx_pkg::nx_instr_t              fetch_data_i
    , input  logic                           fetch_stall_i
    // Run status and result
    , output logic                           busy_o
    , output logic                           done_o
    , output logic [nx_pkg::NX_REGS-1:0]     regs_o
);

typedef enum logic [1:0] {
    IDLE,
    FETCH,
    EXEC
} state_t;

state_t                        state_q;
// Program counter and count captured at trigger
logic [nx_pkg::NX_ADDR_W-1:0]  pc_q;
logic [nx_pkg::NX_ADDR_W-1:0]  count_q;
logic [nx_pkg::NX_REGS-1:0]    regs_q;
logic                          at_end;
logic                          op_a;
logic                          op_b;
logic                          result;

assign at_end = (pc_q == count_q);

// Status follows the state directly
assign busy_o = (state_q != IDLE);
// Reached the end of the snapshot
assign done_o = (state_q == FETCH) && at_end;

assign fetch_addr_o = pc_q;
assign fetch_rd_o   = (state_q == FETCH) && !at_end;
assign regs_o       = regs_q;

// Operand select and logic op
always_comb begin : p_eval
    op_a   = regs_q[fetch_data_i.src_a];
    op_b   = regs_q[fetch_data_i.src_b];
    result = op_a;
    case (fetch_data_i.op)
        nx_pkg::OP_INVERT: result = ~op_a;
        nx_pkg::OP_AND:    result = op_a & op_b;
        nx_pkg::OP_NAND:   result = ~(op_a & op_b);
        nx_pkg::OP_OR:     result = op_a | op_b;
        nx_pkg::OP_NOR:    result = ~(op_a | op_b);
        nx_pkg::OP_XOR:    result = op_a ^ op_b;
        nx_pkg::OP_XNOR:   result = ~(op_a ^ op_b);
        nx_pkg::OP_COPY:   result = op_a;
    endcase
end

// Run sequencing
always_ff @(posedge clk_i, posedge rst_i) begin : p_seq
    if (rst_i) begin
        state_q <= IDLE;
        pc_q    <= '0;
        count_q <= '0;
        regs_q  <= '0;
    end else begin
        case (state_q)
            IDLE: begin
                // Inputs into the low byte, upper registers carry over
                if (trigger_i) begin
                    regs_q[7:0] <= trig_inputs_i;
                    count_q     <= instr_count_i;
                    pc_q        <= '0;
                    state_q     <= FETCH;
                end
            end
            FETCH: begin
                // Stalled fetch is simply repeated
                if (at_end) begin
                    state_q <= IDLE;
                end else if (!fetch_stall_i) begin
                    state_q <= EXEC;
                end
            end
            EXEC: begin
                regs_q[fetch_data_i.tgt] <= result;
                pc_q                     <= pc_q + 1'b1;
                state_q                  <= FETCH;
            end
            default: state_q <= IDLE;
        endcase
    end
end

endmodule : nx_node_core

//--- logic/nx_node_store.sv
// Instruction and control storage in one dual-port RAM
// Port A carries the instruction list, port B the control block
module nx_node_store #(
      parameter int MAX_INSTRS = 512
    , parameter int MAX_CTRL   = 512
) (
      input  logic                           clk_i
    , input  logic                           rst_i
    // Number of appended instructions
    , output logic [$clog2(MAX_INSTRS)-1:0]  instr_count_o
    // Instruction append
    , input  nx_pkg::nx_instr_t              store_data_i
    , input  logic                           store_valid_i
    // Instruction fetch
    , input  logic [$clog2(MAX_INSTRS)-1:0]  fetch_addr_i
    , input  logic                           fetch_rd_i
    , output nx_pkg::nx_instr_t              fetch_data_o
    , output logic                           fetch_stall_o
    // Control block access
    , input  logic [$clog2(MAX_CTRL)-1:0]    ctrl_addr_i
    , input  logic [nx_pkg::NX_CTRL_W-1:0]   ctrl_wr_data_i
    , input  logic                           ctrl_wr_en_i
    , input  logic                           ctrl_rd_en_i
    , output logic [nx_pkg::NX_CTRL_W-1:0]   ctrl_rd_data_o
);

localparam int INSTR_ADDR_W = $clog2(MAX_INSTRS);
localparam int CTRL_ADDR_W  = $clog2(MAX_CTRL);
// Each half is sized for the deeper of the two stores
localparam int HALF_ADDR_W  = (INSTR_ADDR_W > CTRL_ADDR_W) ? INSTR_ADDR_W : CTRL_ADDR_W;
localparam int DATA_W       = (nx_pkg::NX_INSTR_W > nx_pkg::NX_CTRL_W) ?
                              nx_pkg::NX_INSTR_W : nx_pkg::NX_CTRL_W;

logic [INSTR_ADDR_W-1:0] instr_count_q;
logic [INSTR_ADDR_W-1:0] instr_addr;
logic [HALF_ADDR_W:0]    addr_a;
logic [HALF_ADDR_W:0]    addr_b;
logic [DATA_W-1:0]       wr_data_a;
logic [DATA_W-1:0]       wr_data_b;
logic [DATA_W-1:0]       rd_data_a;
logic [DATA_W-1:0]       rd_data_b;

assign instr_count_o = instr_count_q;

// Loads own port A and hold off any fetch
assign fetch_stall_o = store_valid_i;
assign instr_addr    = store_valid_i ? instr_count_q : fetch_addr_i;

// Top address bit low for instructions, high for control
assign addr_a    = {1'b0, HALF_ADDR_W'(instr_addr)};
assign addr_b    = {1'b1, HALF_ADDR_W'(ctrl_addr_i)};
assign wr_data_a = DATA_W'(store_data_i);
assign wr_data_b = DATA_W'(ctrl_wr_data_i);

assign fetch_data_o   = nx_pkg::nx_instr_t'(rd_data_a[nx_pkg::NX_INSTR_W-1:0]);
assign ctrl_rd_data_o = rd_data_b[nx_pkg::NX_CTRL_W-1:0];

nx_ram #(
      .ADDRESS_WIDTH(HALF_ADDR_W + 1)
    , .DATA_WIDTH   (DATA_W         )
) u_ram (
      .clk_a_i    (clk_i                       )
    , .rst_a_i    (rst_i                       )
    , .addr_a_i   (addr_a                      )
    , .wr_data_a_i(wr_data_a                   )
    , .wr_en_a_i  (store_valid_i               )
    , .en_a_i     (store_valid_i || fetch_rd_i )
    , .rd_data_a_o(rd_data_a                   )
    , .clk_b_i    (clk_i                       )
    , .rst_b_i    (rst_i                       )
    , .addr_b_i   (addr_b                      )
    , .wr_data_b_i(wr_data_b                   )
    , .wr_en_b_i  (ctrl_wr_en_i                )
    , .en_b_i     (ctrl_wr_en_i || ctrl_rd_en_i)
    , .rd_data_b_o(rd_data_b                   )
);

// Append pointer
always_ff @(posedge clk_i, posedge rst_i) begin : p_count
    if (rst_i) begin
        instr_count_q <= '0;
    end else if (store_valid_i) begin
        instr_count_q <= instr_count_q + 1'b1;
    end
end

endmodule : nx_node_store

//--- logic/nx_pkg.sv
// Widths, encodings and message layout shared across the node
package nx_pkg;

// Instruction word width
localparam int NX_INSTR_W = 15;
// Control entry width
localparam int NX_CTRL_W = 12;
// Message address width and upper bound on store depth
localparam int NX_ADDR_W = 9;
// Single-bit working registers
localparam int NX_REGS = 16;
// Register select field width
localparam int NX_REG_SEL_W = $clog2(NX_REGS);

// Inbound message commands
typedef enum logic [1:0] {
    CMD_LOAD_INSTR,
    CMD_CTRL_WRITE,
    CMD_CTRL_READ,
    CMD_TRIGGER
} nx_cmd_e;

// Two-input logic operations
typedef enum logic [2:0] {
    OP_INVERT, // not of A
    OP_AND,
    OP_NAND,
    OP_OR,
    OP_NOR,
    OP_XOR,
    OP_XNOR,
    OP_COPY    // A passed through
} nx_op_e;

// Packed instruction word
typedef struct packed {
    nx_op_e                  op;
    logic [NX_REG_SEL_W-1:0] src_a;
    logic [NX_REG_SEL_W-1:0] src_b;
    logic [NX_REG_SEL_W-1:0] tgt;
} nx_instr_t;

// Inbound command message
typedef struct packed {
    nx_cmd_e               cmd;
    logic [NX_ADDR_W-1:0]  addr;
    logic [NX_INSTR_W-1:0] data;
} nx_msg_t;

endpackage : nx_pkg

//--- logic/nx_ram.sv
// True dual-port synchronous RAM
// Both ports are write-first with registered read data
module nx_ram #(
      parameter int ADDRESS_WIDTH = 10
    , parameter int DATA_WIDTH    = 15
) (
    // Port A
      input  logic                     clk_a_i
    , input  logic                     rst_a_i
    , input  logic [ADDRESS_WIDTH-1:0] addr_a_i
    , input  logic [DATA_WIDTH-1:0]    wr_data_a_i
    , input  logic                     wr_en_a_i
    , input  logic                     en_a_i
    , output logic [DATA_WIDTH-1:0]    rd_data_a_o
    // Port B
    , input  logic                     clk_b_i
    , input  logic                     rst_b_i
    , input  logic [ADDRESS_WIDTH-1:0] addr_b_i
    , input  logic [DATA_WIDTH-1:0]    wr_data_b_i
    , input  logic                     wr_en_b_i
    , input  logic                     en_b_i
    , output logic [DATA_WIDTH-1:0]    rd_data_b_o
);

localparam int DEPTH = 2 ** ADDRESS_WIDTH;

// Storage shared by both ports
logic [DATA_WIDTH-1:0] mem [DEPTH];

// Port A array write
always @(posedge clk_a_i) begin
    if (en_a_i && wr_en_a_i) begin
        mem[addr_a_i] <= wr_data_a_i;
    end
end

// Port A read register
always_ff @(posedge clk_a_i, posedge rst_a_i) begin : p_read_a
    if (rst_a_i) begin
        rd_data_a_o <= '0;
    end else if (en_a_i) begin
        // Write returns the new word
        rd_data_a_o <= wr_en_a_i ? wr_data_a_i : mem[addr_a_i];
    end
end

// Port B array write
always @(posedge clk_b_i) begin
    if (en_b_i && wr_en_b_i) begin
        mem[addr_b_i] <= wr_data_b_i;
    end
end

// Port B read register
always_ff @(posedge clk_b_i, posedge rst_b_i) begin : p_read_b
    if (rst_b_i) begin
        rd_data_b_o <= '0;
    end else if (en_b_i) begin
        rd_data_b_o <= wr_en_b_i ? wr_data_b_i : mem[addr_b_i];
    end
end

endmodule : nx_ram
